// ==== Makefile ====
SIM      = verilator
TOP      = ccip_sniffer_tb
FILELIST = tb.f
MDIR     = obj_dir
FLAGS    = --timing --assert --top-module $(TOP)
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST)

sim:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --Mdir $(MDIR) -o sim_bin
	-./$(MDIR)/sim_bin > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx '>>> PASS' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(MDIR) $(LOG)

// ==== hw/ccip_sniffer.sv ====
module ccip_sniffer #(
   parameter int mmio_timeout = 64
) (
   input  logic                   clk,
   input  logic                   rst_n,
   // accelerator request channels
   input  sniff_pkg::tx_req_t     c0_tx,
   input  sniff_pkg::tx_req_t     c1_tx,
   input  logic                   c0_tx_full,
   input  logic                   c1_tx_full,
   // mmio traffic
   input  sniff_pkg::mmio_req_t   mmio_req,
   input  sniff_pkg::mmio_rsp_t   mmio_rsp,
   // sticky first error
   output logic                   error_valid,
   output sniff_pkg::sniff_code_e error_code,
   output logic [7:0]             error_count
);
   import sniff_pkg::*;

   sniff_flags_t tx_flags;
   sniff_flags_t mmio_flags;

   // type, alignment and overflow on c0 and c1
   tx_req_checker tx_req_checker_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .c0_tx      (c0_tx),
      .c1_tx      (c1_tx),
      .c0_tx_full (c0_tx_full),
      .c1_tx_full (c1_tx_full),
      .tx_flags   (tx_flags)
   );

   // per-tid read response tracking
   mmio_rsp_tracker #(
      .mmio_timeout (mmio_timeout)
   ) mmio_rsp_tracker_inst (
      .clk        (clk),
      .rst_n      (rst_n),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .mmio_flags (mmio_flags)
   );

   // first error and violation count
   sniff_error_latch sniff_error_latch_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .tx_flags    (tx_flags),
      .mmio_flags  (mmio_flags),
      .error_valid (error_valid),
      .error_code  (error_code),
      .error_count (error_count)
   );

endmodule

// ==== hw/mmio_rsp_tracker.sv ====
module mmio_rsp_tracker #(
   parameter int mmio_timeout = 64
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  sniff_pkg::mmio_req_t    mmio_req,
   input  sniff_pkg::mmio_rsp_t    mmio_rsp,
   output sniff_pkg::sniff_flags_t mmio_flags
);
   import sniff_pkg::*;

   // one entry per tid
   localparam int n_tid = 1 << tid_w;
   // wide enough to hold the timeout value itself
   localparam int timer_w = $clog2(mmio_timeout + 1);

   logic [n_tid-1:0]   pending;
   logic [timer_w-1:0] timer [n_tid];
   logic [n_tid-1:0]   req_sel;
   logic [n_tid-1:0]   rsp_sel;
   logic [n_tid-1:0]   expired;
   logic               unsolicited;

   // one-hot decode of the read request tid
   // write requests never enter the table
   assign req_sel = mmio_req.rd_valid ? (n_tid'(1) << mmio_req.tid) : '0;

   // one-hot decode of the response tid
   assign rsp_sel = mmio_rsp.valid ? (n_tid'(1) << mmio_rsp.tid) : '0;

   // response to a tid with nothing outstanding
   // looks at the table before this cycle's request lands
   assign unsolicited = mmio_rsp.valid && !pending[mmio_rsp.tid];

   // entry waited the full allowance
   always_comb begin
      for (int i = 0; i < n_tid; i++) begin
         expired[i] = pending[i] && (timer[i] == timer_w'(mmio_timeout));
      end
   end

   // pending bits
   // response and expiry clear first, a new read then sets
   // so a same-tid request and response leave the tid pending
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pending <= '0;
      end else begin
         pending <= (pending & ~(rsp_sel | expired)) | req_sel;
      end
   end

   // cycle timers
   // only meaningful while the entry is pending
   always_ff @(posedge clk) begin
      for (int i = 0; i < n_tid; i++) begin
         if (req_sel[i]) begin
            timer[i] <= '0;
         end else if (pending[i]) begin
            // stops at the limit since expiry drops pending
            timer[i] <= timer[i] + 1'b1;
         end
      end
   end

   // flags
   // unsolicited one cycle after the response
   // timeout once per expired entry
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mmio_flags <= '0;
      end else begin
         mmio_flags                        <= '0;
         mmio_flags.mmio_rdrsp_unsolicited <= unsolicited;
         mmio_flags.mmio_rdrsp_timeout     <= |expired;
      end
   end

endmodule

// ==== hw/sniff_error_latch.sv ====
module sniff_error_latch (
   input  logic                    clk,
   input  logic                    rst_n,
   input  sniff_pkg::sniff_flags_t tx_flags,
   input  sniff_pkg::sniff_flags_t mmio_flags,
   output logic                    error_valid,
   output sniff_pkg::sniff_code_e  error_code,
   output logic [7:0]              error_count
);
   import sniff_pkg::*;

   localparam int n_flags = $bits(sniff_flags_t);

   logic [n_flags-1:0] flag_bits;
   logic               any_flag;
   sniff_code_e        first_code;

   // both sources only drive their own bits
   assign flag_bits = tx_flags | mmio_flags;
   assign any_flag  = |flag_bits;

   // priority encode
   // msb is code 1, so scanning upward leaves the lowest code
   always_comb begin
      first_code = sniff_no_error;
      for (int i = 0; i < n_flags; i++) begin
         if (flag_bits[i]) begin
            first_code = sniff_code_e'(5'(n_flags - i));
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         error_valid <= 1'b0;
         error_code  <= sniff_no_error;
         error_count <= '0;
      end else if (any_flag) begin
         // code frozen after the first violating cycle
         if (!error_valid) begin
            error_valid <= 1'b1;
            error_code  <= first_code;
         end
         // saturating count of violating cycles
         if (error_count != 8'hff) begin
            error_count <= error_count + 8'd1;
         end
      end
   end

endmodule

// ==== hw/sniff_pkg.sv ====
package sniff_pkg;

   // cache-line address width
   localparam int cl_addr_w = 42;
   // mmio transaction id width
   localparam int tid_w = 9;

   // request types seen on the tx channels
   // read and write codes kept apart so one compare decides the channel
   typedef enum logic [3:0] {
      wrline_i = 4'h0,
      wrline_m = 4'h1,
      wrfence  = 4'h4,
      rdline_i = 4'h8,
      rdline_s = 4'h9
   } req_type_e;

   // number of lines in a multi-line request
   typedef enum logic [1:0] {
      cl_1 = 2'b00,
      cl_2 = 2'b01,
      cl_3 = 2'b10,
      cl_4 = 2'b11
   } cl_len_e;

   // request header, shared by c0 and c1
   // sop only has meaning on the write channel
   typedef struct packed {
      logic [1:0]           vc_sel;
      logic                 sop;
      cl_len_e              cl_len;
      req_type_e            req_type;
      logic [cl_addr_w-1:0] address;
      logic [15:0]          mdata;
   } req_hdr_t;

   // one beat on a request channel
   typedef struct packed {
      logic     valid;
      req_hdr_t hdr;
   } tx_req_t;

   // host to accelerator mmio request
   typedef struct packed {
      logic             rd_valid;
      logic             wr_valid;
      logic [15:0]      address;
      logic [1:0]       length;
      logic [tid_w-1:0] tid;
   } mmio_req_t;

   // accelerator read response, only the tid matters here
   typedef struct packed {
      logic             valid;
      logic [tid_w-1:0] tid;
   } mmio_rsp_t;

   // error codes
   // lower value wins when several rules fire in one cycle
   typedef enum logic [4:0] {
      sniff_no_error         = 5'd0,
      c0tx_invalid_reqtype   = 5'd1,
      c0tx_overflow          = 5'd2,
      c0tx_addralign_2       = 5'd3,
      c0tx_addralign_4       = 5'd4,
      c1tx_invalid_reqtype   = 5'd5,
      c1tx_overflow          = 5'd6,
      c1tx_addralign_2       = 5'd7,
      c1tx_addralign_4       = 5'd8,
      mmio_rdrsp_timeout     = 5'd9,
      mmio_rdrsp_unsolicited = 5'd10
   } sniff_code_e;

   // one flag per code, same order as sniff_code_e
   // first field sits in the msb
   typedef struct packed {
      logic c0tx_invalid_reqtype;
      logic c0tx_overflow;
      logic c0tx_addralign_2;
      logic c0tx_addralign_4;
      logic c1tx_invalid_reqtype;
      logic c1tx_overflow;
      logic c1tx_addralign_2;
      logic c1tx_addralign_4;
      logic mmio_rdrsp_timeout;
      logic mmio_rdrsp_unsolicited;
   } sniff_flags_t;

endpackage

// ==== hw/tx_req_checker.sv ====
module tx_req_checker (
   input  logic                    clk,
   input  logic                    rst_n,
   input  sniff_pkg::tx_req_t      c0_tx,
   input  sniff_pkg::tx_req_t      c1_tx,
   input  logic                    c0_tx_full,
   input  logic                    c1_tx_full,
   output sniff_pkg::sniff_flags_t tx_flags
);
   import sniff_pkg::*;

   // alignment faults of one header as {cl_2 fault, cl_4 fault}
   function automatic logic [1:0] align_err(input req_hdr_t hdr);
      logic mis_2;
      logic mis_4;
      // 2-line request needs an even line address
      mis_2 = (hdr.cl_len == cl_2) && hdr.address[0];
      // 4-line request needs both low bits clear
      mis_4 = (hdr.cl_len == cl_4) && (hdr.address[1:0] != 2'b00);
      return {mis_2, mis_4};
   endfunction

   logic         c0_legal;
   logic         c1_legal;
   logic         c1_wrline;
   logic [1:0]   c0_align;
   logic [1:0]   c1_align;
   sniff_flags_t flags_next;

   // c0 carries reads only
   assign c0_legal = c0_tx.hdr.req_type inside {rdline_s, rdline_i};

   // c1 carries writes and fences
   assign c1_legal  = c1_tx.hdr.req_type inside {wrline_i, wrline_m, wrfence};
   assign c1_wrline = c1_tx.hdr.req_type inside {wrline_i, wrline_m};

   assign c0_align = align_err(c0_tx.hdr);
   assign c1_align = align_err(c1_tx.hdr);

   always_comb begin
      flags_next = '0;

      // read channel
      flags_next.c0tx_invalid_reqtype = c0_tx.valid && !c0_legal;
      flags_next.c0tx_overflow        = c0_tx.valid && c0_tx_full;
      // alignment only judged on a legal read
      flags_next.c0tx_addralign_2     = c0_tx.valid && c0_legal && c0_align[1];
      flags_next.c0tx_addralign_4     = c0_tx.valid && c0_legal && c0_align[0];

      // write channel
      flags_next.c1tx_invalid_reqtype = c1_tx.valid && !c1_legal;
      flags_next.c1tx_overflow        = c1_tx.valid && c1_tx_full;
      // first beat of a write line only, later beats follow on
      flags_next.c1tx_addralign_2     = c1_tx.valid && c1_wrline && c1_tx.hdr.sop
                                        && c1_align[1];
      flags_next.c1tx_addralign_4     = c1_tx.valid && c1_wrline && c1_tx.hdr.sop
                                        && c1_align[0];
      // mmio bits belong to the tracker and stay low here
   end

   // one cycle after the offending beat
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tx_flags <= '0;
      end else begin
         tx_flags <= flags_next;
      end
   end

endmodule

// ==== tb.f ====
hw/sniff_pkg.sv
hw/tx_req_checker.sv
hw/mmio_rsp_tracker.sv
hw/sniff_error_latch.sv
hw/ccip_sniffer.sv
tests/tb_clock_gen.sv
tests/ccip_sniffer_tb.sv

// ==== tests/ccip_sniffer_tb.sv ====
module ccip_sniffer_tb;
   import sniff_pkg::*;

   localparam int mmio_timeout = 32;
   // rough length of all tests together, resets included
   localparam int test_cycles = 600;
   localparam int watchdog_cycles = test_cycles + 200;

   logic        clk;
   logic        rst_n;
   tx_req_t     c0_tx;
   tx_req_t     c1_tx;
   logic        c0_tx_full;
   logic        c1_tx_full;
   mmio_req_t   mmio_req;
   mmio_rsp_t   mmio_rsp;
   logic        error_valid;
   sniff_code_e error_code;
   logic [7:0]  error_count;

   // expected outputs, updated 2 cycles after each beat
   logic        check_en;
   logic        exp_valid;
   sniff_code_e exp_code;
   logic [7:0]  exp_count;
   string       test_name;
   integer      seed;

   tb_clock_gen #(.period(10)) clock_gen_inst (.clk(clk));

   ccip_sniffer #(
      .mmio_timeout (mmio_timeout)
   ) ccip_sniffer_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .c0_tx       (c0_tx),
      .c1_tx       (c1_tx),
      .c0_tx_full  (c0_tx_full),
      .c1_tx_full  (c1_tx_full),
      .mmio_req    (mmio_req),
      .mmio_rsp    (mmio_rsp),
      .error_valid (error_valid),
      .error_code  (error_code),
      .error_count (error_count)
   );

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display(">>> FAIL");
      $fatal(1, "stopped in test %s", test_name);
   endtask

   task automatic report_mismatch(input string what, input string exp_s, input string act_s);
      report_failure($sformatf("CHECK FAILED test %s: %s expected %s actual %s",
                               test_name, what, exp_s, act_s));
   endtask

   // outputs track the expected values whenever checking is on
   valid_check: assert property (@(posedge clk) !check_en || error_valid == exp_valid)
      else report_mismatch("error_valid", $sformatf("%0d", $sampled(exp_valid)),
                           $sformatf("%0d", $sampled(error_valid)));
   code_check: assert property (@(posedge clk) !check_en || error_code == exp_code)
      else report_mismatch("error_code", $sformatf("%0d", $sampled(exp_code)),
                           $sformatf("%0d", $sampled(error_code)));
   count_check: assert property (@(posedge clk) !check_en || error_count == exp_count)
      else report_mismatch("error_count", $sformatf("%0d", $sampled(exp_count)),
                           $sformatf("%0d", $sampled(error_count)));

   function automatic logic [cl_addr_w-1:0] rand_addr();
      logic [63:0] r;
      r = {$random(seed), $random(seed)};
      return r[cl_addr_w-1:0];
   endfunction

   // random address that obeys the multi-line alignment rule
   function automatic logic [cl_addr_w-1:0] aligned_addr(input cl_len_e len);
      logic [cl_addr_w-1:0] a;
      a = rand_addr();
      if (len == cl_2) a[0] = 1'b0;
      if (len == cl_4) a[1:0] = 2'b00;
      return a;
   endfunction

   function automatic tx_req_t make_req(input req_type_e t, input cl_len_e len,
                                        input logic [cl_addr_w-1:0] addr, input logic sop);
      tx_req_t     b;
      logic [31:0] r;
      r = $random(seed);
      b.valid        = 1'b1;
      b.hdr.vc_sel   = r[17:16];
      b.hdr.sop      = sop;
      b.hdr.cl_len   = len;
      b.hdr.req_type = t;
      b.hdr.address  = addr;
      b.hdr.mdata    = r[15:0];
      return b;
   endfunction

   function automatic mmio_req_t make_mmio(input logic rd, input logic [tid_w-1:0] tid);
      mmio_req_t   m;
      logic [31:0] r;
      r = $random(seed);
      m.rd_valid = rd;
      m.wr_valid = !rd;
      m.address  = r[15:0];
      m.length   = r[17:16];
      m.tid      = tid;
      return m;
   endfunction

   // 1, 2 or 4 lines
   function automatic cl_len_e pick_len(input logic [1:0] sel);
      if (sel == 2'd1) return cl_2;
      if (sel == 2'd2) return cl_4;
      return cl_1;
   endfunction

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic apply_reset(input string name);
      @(posedge clk);
      test_name = name;
      check_en   <= 1'b0;
      rst_n      <= 1'b0;
      c0_tx      <= '0;
      c1_tx      <= '0;
      c0_tx_full <= 1'b0;
      c1_tx_full <= 1'b0;
      mmio_req   <= '0;
      mmio_rsp   <= '0;
      repeat (16) @(posedge clk);
      rst_n     <= 1'b1;
      exp_valid <= 1'b0;
      exp_code  <= sniff_no_error;
      exp_count <= '0;
      check_en  <= 1'b1;
   endtask

   // one beat on both request channels, idle on the next edge
   task automatic send_tx(input tx_req_t b0, input tx_req_t b1, input logic f0, input logic f1);
      @(posedge clk);
      c0_tx      <= b0;
      c1_tx      <= b1;
      c0_tx_full <= f0;
      c1_tx_full <= f1;
      @(posedge clk);
      c0_tx      <= '0;
      c1_tx      <= '0;
      c0_tx_full <= 1'b0;
      c1_tx_full <= 1'b0;
   endtask

   task automatic send_mmio(input mmio_req_t req, input mmio_rsp_t rsp);
      @(posedge clk);
      mmio_req <= req;
      mmio_rsp <= rsp;
      @(posedge clk);
      mmio_req <= '0;
      mmio_rsp <= '0;
   endtask

   // called right after a send task, lands 2 cycles after the beat
   task automatic expect_state(input logic v, input sniff_code_e code, input logic [7:0] count);
      @(posedge clk);
      exp_valid <= v;
      exp_code  <= code;
      exp_count <= count;
      check_en  <= 1'b1;
   endtask

   // random legal traffic, one outstanding mmio read answered in 1 to 10 cycles
   task automatic run_legal_traffic();
      tx_req_t          b0;
      tx_req_t          b1;
      mmio_req_t        req;
      mmio_rsp_t        rsp;
      cl_len_e          len;
      logic [tid_w-1:0] tid;
      logic [31:0]      r;
      int               wait_left;
      wait_left = 0;
      tid = '0;
      for (int n = 0; n < 200; n++) begin
         r = $random(seed);
         len = pick_len(r[3:2]);
         b0 = make_req(r[1] ? rdline_s : rdline_i, len, aligned_addr(len), 1'b0);
         b0.valid = r[0];
         len = pick_len(r[8:7]);
         b1 = make_req(r[5] ? wrfence : (r[4] ? wrline_m : wrline_i), len,
                       aligned_addr(len), r[6]);
         b1.valid = r[9];
         req = '0;
         rsp = '0;
         if (wait_left == 1) begin
            rsp.valid = 1'b1;
            rsp.tid = tid;
            wait_left = 0;
         end else if (wait_left > 1) begin
            wait_left--;
         end else if (r[10]) begin
            tid = r[28:20];
            req = make_mmio(1'b1, tid);
            wait_left = 1 + int'(r[14:11]) % 10;
         end else if (r[15]) begin
            // writes never need an answer
            req = make_mmio(1'b0, r[28:20]);
         end
         @(posedge clk);
         c0_tx    <= b0;
         c1_tx    <= b1;
         mmio_req <= req;
         mmio_rsp <= rsp;
      end
      @(posedge clk);
      c0_tx    <= '0;
      c1_tx    <= '0;
      mmio_req <= '0;
      mmio_rsp <= '0;
      idle(4);
   endtask

   task automatic run_timeout();
      logic [tid_w-1:0] tid;
      int               edges;
      logic             seen;
      tid = tid_w'($random(seed));
      @(posedge clk);
      // window measured by hand, continuous checks paused
      check_en <= 1'b0;
      mmio_req <= make_mmio(1'b1, tid);
      edges = 0;
      seen = 1'b0;
      while (!seen && edges < 40) begin
         @(posedge clk);
         mmio_req <= '0;
         edges++;
         @(negedge clk);
         seen = error_valid;
      end
      if (!seen) begin
         report_failure("no timeout error within 40 cycles of an unanswered mmio read");
      end
      assert (edges >= mmio_timeout && edges <= mmio_timeout + 4)
         else report_mismatch("timeout latency",
                              $sformatf("%0d to %0d", mmio_timeout, mmio_timeout + 4),
                              $sformatf("%0d", edges));
      assert (error_code == mmio_rdrsp_timeout)
         else report_mismatch("error_code", $sformatf("%0d", mmio_rdrsp_timeout),
                              $sformatf("%0d", error_code));
      expect_state(1'b1, mmio_rdrsp_timeout, 8'd1);
      idle(4);
   endtask

   initial begin
      logic [cl_addr_w-1:0] addr;
      logic [tid_w-1:0]     tid;
      seed = 92;
      check_en   = 1'b0;
      exp_valid  = 1'b0;
      exp_code   = sniff_no_error;
      exp_count  = '0;
      test_name  = "init";
      rst_n      <= 1'b0;
      c0_tx      <= '0;
      c1_tx      <= '0;
      c0_tx_full <= 1'b0;
      c1_tx_full <= 1'b0;
      mmio_req   <= '0;
      mmio_rsp   <= '0;

      apply_reset("legal_traffic");
      run_legal_traffic();

      // read channel carrying a write
      apply_reset("c0_invalid_type");
      send_tx(make_req(wrline_i, cl_1, rand_addr(), 1'b0), '0, 1'b0, 1'b0);
      expect_state(1'b1, c0tx_invalid_reqtype, 8'd1);
      idle(4);
      apply_reset("c1_invalid_type");
      send_tx('0, make_req(rdline_s, cl_1, rand_addr(), 1'b1), 1'b0, 1'b0);
      expect_state(1'b1, c1tx_invalid_reqtype, 8'd1);
      idle(4);

      apply_reset("c0_align_2");
      addr = rand_addr();
      addr[0] = 1'b1;
      send_tx(make_req(rdline_i, cl_2, addr, 1'b0), '0, 1'b0, 1'b0);
      expect_state(1'b1, c0tx_addralign_2, 8'd1);
      idle(4);
      apply_reset("c1_align_4");
      addr = rand_addr();
      addr[1:0] = 2'b10;
      send_tx('0, make_req(wrline_m, cl_4, addr, 1'b1), 1'b0, 1'b0);
      expect_state(1'b1, c1tx_addralign_4, 8'd1);
      idle(4);
      // later beats of a packet are not judged
      apply_reset("c1_align_no_sop");
      send_tx('0, make_req(wrline_m, cl_4, addr, 1'b0), 1'b0, 1'b0);
      expect_state(1'b0, sniff_no_error, 8'd0);
      idle(4);

      apply_reset("c1_overflow");
      send_tx('0, make_req(wrline_i, cl_1, rand_addr(), 1'b1), 1'b0, 1'b1);
      expect_state(1'b1, c1tx_overflow, 8'd1);
      idle(4);
      // c0 type error outranks c1 overflow in the same cycle
      apply_reset("priority");
      send_tx(make_req(wrline_i, cl_1, rand_addr(), 1'b0),
              make_req(wrline_i, cl_1, rand_addr(), 1'b1), 1'b0, 1'b1);
      expect_state(1'b1, c0tx_invalid_reqtype, 8'd1);
      idle(2);
      send_tx('0, make_req(wrline_m, cl_1, rand_addr(), 1'b1), 1'b0, 1'b1);
      expect_state(1'b1, c0tx_invalid_reqtype, 8'd2);
      idle(4);

      apply_reset("mmio_unsolicited");
      tid = tid_w'($random(seed));
      send_mmio('0, '{valid: 1'b1, tid: tid});
      expect_state(1'b1, mmio_rdrsp_unsolicited, 8'd1);
      idle(4);
      // first answer is legal, the repeat is not
      apply_reset("mmio_repeat_rsp");
      send_mmio(make_mmio(1'b1, tid), '0);
      send_mmio('0, '{valid: 1'b1, tid: tid});
      send_mmio('0, '{valid: 1'b1, tid: tid});
      expect_state(1'b1, mmio_rdrsp_unsolicited, 8'd1);
      idle(4);

      apply_reset("mmio_timeout");
      run_timeout();

      $display(">>> PASS");
      $finish;
   end

   // watchdog against a hung sequence
   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog: run still going after %0d cycles in test %s",
               watchdog_cycles, test_name);
      $display(">>> FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

// ==== tests/tb_clock_gen.sv ====
module tb_clock_gen #(
   parameter int period = 10
) (
   output logic clk
);

   // free running, low at time 0
   initial begin
      clk = 1'b0;
   end

   always #(period / 2) clk = ~clk;

endmodule
